// File: hdl/dma_regs_pkg.sv
// ---------------------------------------------------------------------------
// DMA register file shared definitions
// Register map offsets, control and status bit positions
// Response, select and FSM state enums
// Write request, configuration and status structs, address decoder
// ---------------------------------------------------------------------------

package dma_regs_pkg;

    localparam int unsigned DATA_W = 32;         // Word based register map
    localparam int unsigned STRB_W = DATA_W / 8; // One strobe per byte lane

    // Register map, byte offsets within the low address byte
    localparam logic [7:0] ADDR_CTRL      = 8'h00;
    localparam logic [7:0] ADDR_STATUS    = 8'h04; // Read only
    localparam logic [7:0] ADDR_S2MM_ADDR = 8'h10;
    localparam logic [7:0] ADDR_S2MM_LEN  = 8'h14;
    localparam logic [7:0] ADDR_MM2S_ADDR = 8'h20;
    localparam logic [7:0] ADDR_MM2S_LEN  = 8'h24;

    // Control word bits
    localparam int unsigned CTRL_MM2S_START = 0;
    localparam int unsigned CTRL_S2MM_START = 1;
    localparam int unsigned CTRL_MM2S_RST   = 8;
    localparam int unsigned CTRL_S2MM_RST   = 9;

    // Status word bits, the rest read as zero
    localparam int unsigned STAT_MM2S_BUSY = 0;
    localparam int unsigned STAT_S2MM_BUSY = 1;
    localparam int unsigned STAT_S2MM_IRQ  = 2;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    typedef enum logic [2:0] {
        SEL_CTRL,
        SEL_STATUS,
        SEL_S2MM_ADDR,
        SEL_S2MM_LEN,
        SEL_MM2S_ADDR,
        SEL_MM2S_LEN,
        SEL_NONE       // Unmapped or misaligned
    } reg_sel_e;

    typedef enum logic [1:0] {WR_ADDR, WR_DATA, WR_RESP} wr_state_e;
    typedef enum logic {RD_ADDR, RD_RESP} rd_state_e;

    // Write request from the bus side into the register bank
    typedef struct packed {
        logic              valid;
        reg_sel_e          sel;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } reg_wr_t;

    typedef struct packed {
        logic [DATA_W-1:0] ctrl;
        logic [DATA_W-1:0] s2mm_addr;
        logic [DATA_W-1:0] s2mm_len;
        logic [DATA_W-1:0] mm2s_addr;
        logic [DATA_W-1:0] mm2s_len;
    } dma_cfg_t;

    typedef struct packed {
        logic mm2s_busy;
        logic s2mm_busy;
        logic mm2s_irq;
        logic s2mm_irq;
    } dma_status_t;

    // Exact match only, so misaligned offsets fall to SEL_NONE
    function automatic reg_sel_e decode_addr(input logic [7:0] addr);
        case (addr)
            ADDR_CTRL:      return SEL_CTRL;
            ADDR_STATUS:    return SEL_STATUS;
            ADDR_S2MM_ADDR: return SEL_S2MM_ADDR;
            ADDR_S2MM_LEN:  return SEL_S2MM_LEN;
            ADDR_MM2S_ADDR: return SEL_MM2S_ADDR;
            ADDR_MM2S_LEN:  return SEL_MM2S_LEN;
            default:        return SEL_NONE;
        endcase
    endfunction

endpackage

// File: hdl/axil_write_ctrl.sv
// ---------------------------------------------------------------------------
// AXI4-Lite write channel controller
// Address phase, data phase and response phase FSM
// Decodes the target and issues one strobed write request per transfer
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module axil_write_ctrl #(
    parameter int unsigned AXI_ADDR_W = 32
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // AW channel
    input  logic [AXI_ADDR_W-1:0]             awaddr_i,
    input  logic                              awvalid_i,
    output logic                              awready_o,
    // W channel
    input  logic [dma_regs_pkg::DATA_W-1:0]   wdata_i,
    input  logic [dma_regs_pkg::STRB_W-1:0]   wstrb_i,
    input  logic                              wvalid_i,
    output logic                              wready_o,
    // B channel
    output dma_regs_pkg::axi_resp_e           bresp_o,
    output logic                              bvalid_o,
    input  logic                              bready_i,
    // Request into the register bank
    output dma_regs_pkg::reg_wr_t             wr_req_o
);

    dma_regs_pkg::wr_state_e state_q;
    dma_regs_pkg::reg_sel_e  sel_q;   // Target decoded in the address phase

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic sel_ok;                     // Target is a writable word

    assign aw_hs  = awvalid_i && awready_o;
    assign w_hs   = wvalid_i && wready_o;
    assign b_hs   = bvalid_o && bready_i;
    assign sel_ok = (sel_q != dma_regs_pkg::SEL_NONE) && (sel_q != dma_regs_pkg::SEL_STATUS);

    // Request is live only in the W transfer cycle, committed at the next edge
    assign wr_req_o.valid = w_hs && sel_ok;
    assign wr_req_o.sel   = sel_q;
    assign wr_req_o.data  = wdata_i;
    assign wr_req_o.strb  = wstrb_i;

    // ------------------------------------------------------------------------
    // Channel FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= dma_regs_pkg::WR_ADDR;
            sel_q     <= dma_regs_pkg::SEL_NONE;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            bresp_o   <= dma_regs_pkg::RESP_OKAY;
        end else begin
            case (state_q)
                dma_regs_pkg::WR_ADDR: begin
                    awready_o <= 1'b1;           // Rises one cycle after reset
                    if (aw_hs) begin
                        sel_q     <= dma_regs_pkg::decode_addr(awaddr_i[7:0]);
                        awready_o <= 1'b0;
                        wready_o  <= 1'b1;
                        state_q   <= dma_regs_pkg::WR_DATA;
                    end
                end
                dma_regs_pkg::WR_DATA: begin
                    if (w_hs) begin
                        wready_o <= 1'b0;
                        bvalid_o <= 1'b1;        // Same edge as the register update
                        bresp_o  <= sel_ok ? dma_regs_pkg::RESP_OKAY
                                           : dma_regs_pkg::RESP_SLVERR;
                        state_q  <= dma_regs_pkg::WR_RESP;
                    end
                end
                dma_regs_pkg::WR_RESP: begin
                    if (b_hs) begin               // No new AW until B is taken
                        bvalid_o  <= 1'b0;
                        awready_o <= 1'b1;
                        state_q   <= dma_regs_pkg::WR_ADDR;
                    end
                end
                default: begin
                    awready_o <= 1'b0;
                    wready_o  <= 1'b0;
                    bvalid_o  <= 1'b0;
                    state_q   <= dma_regs_pkg::WR_ADDR;
                end
            endcase
        end
    end

    // Response held stable under back-pressure
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

    // Address and data phases never overlap
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(awready_o && wready_o));

endmodule

// File: hdl/dma_cfg_regs.sv
// ---------------------------------------------------------------------------
// DMA configuration register bank
// Commits byte-strobed writes into the five writable words
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module dma_cfg_regs (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  dma_regs_pkg::reg_wr_t  wr_req_i,
    output dma_regs_pkg::dma_cfg_t cfg_o
);

    dma_regs_pkg::dma_cfg_t cfg_q;

    logic [dma_regs_pkg::DATA_W-1:0] cur_word;  // Current value of the target
    logic [dma_regs_pkg::DATA_W-1:0] new_word;  // After the byte merge

    // Strobe merge on the selected word
    always_comb begin
        case (wr_req_i.sel)
            dma_regs_pkg::SEL_CTRL:      cur_word = cfg_q.ctrl;
            dma_regs_pkg::SEL_S2MM_ADDR: cur_word = cfg_q.s2mm_addr;
            dma_regs_pkg::SEL_S2MM_LEN:  cur_word = cfg_q.s2mm_len;
            dma_regs_pkg::SEL_MM2S_ADDR: cur_word = cfg_q.mm2s_addr;
            dma_regs_pkg::SEL_MM2S_LEN:  cur_word = cfg_q.mm2s_len;
            default:                     cur_word = '0;
        endcase
        for (int b = 0; b < dma_regs_pkg::STRB_W; b++) begin
            new_word[b*8 +: 8] = wr_req_i.strb[b] ? wr_req_i.data[b*8 +: 8]
                                                  : cur_word[b*8 +: 8];
        end
    end

    // ------------------------------------------------------------------------
    // Commit stage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cfg_q <= '0;                         // Start and reset bits low
        end else if (wr_req_i.valid) begin
            case (wr_req_i.sel)
                dma_regs_pkg::SEL_CTRL:      cfg_q.ctrl      <= new_word;
                dma_regs_pkg::SEL_S2MM_ADDR: cfg_q.s2mm_addr <= new_word;
                dma_regs_pkg::SEL_S2MM_LEN:  cfg_q.s2mm_len  <= new_word;
                dma_regs_pkg::SEL_MM2S_ADDR: cfg_q.mm2s_addr <= new_word;
                dma_regs_pkg::SEL_MM2S_LEN:  cfg_q.mm2s_len  <= new_word;
                default:                     cfg_q           <= cfg_q; // Hold
            endcase
        end
    end

    assign cfg_o = cfg_q;

    // Write controller filters read-only and unmapped targets
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        wr_req_i.valid |-> (wr_req_i.sel != dma_regs_pkg::SEL_NONE) &&
                           (wr_req_i.sel != dma_regs_pkg::SEL_STATUS));

endmodule

// File: hdl/axil_read_ctrl.sv
// ---------------------------------------------------------------------------
// AXI4-Lite read channel controller
// Decodes the read address, registers data and response
// Status word built from the DMA busy and interrupt flags
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module axil_read_ctrl #(
    parameter int unsigned AXI_ADDR_W = 32
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    // AR channel
    input  logic [AXI_ADDR_W-1:0]           araddr_i,
    input  logic                            arvalid_i,
    output logic                            arready_o,
    // R channel
    output logic [dma_regs_pkg::DATA_W-1:0] rdata_o,
    output dma_regs_pkg::axi_resp_e         rresp_o,
    output logic                            rvalid_o,
    input  logic                            rready_i,
    // Register sources
    input  dma_regs_pkg::dma_cfg_t          cfg_i,
    input  dma_regs_pkg::dma_status_t       status_i
);

    dma_regs_pkg::rd_state_e state_q;
    dma_regs_pkg::reg_sel_e  rd_sel;

    logic [dma_regs_pkg::DATA_W-1:0] stat_word;
    logic [dma_regs_pkg::DATA_W-1:0] rd_mux;
    logic [dma_regs_pkg::DATA_W-1:0] rdata_q;   // Captured on the AR transfer
    logic ar_hs;
    logic r_hs;

    assign ar_hs  = arvalid_i && arready_o;
    assign r_hs   = rvalid_o && rready_i;
    assign rd_sel = dma_regs_pkg::decode_addr(araddr_i[7:0]);

    always_comb begin
        stat_word = '0;
        stat_word[dma_regs_pkg::STAT_MM2S_BUSY] = status_i.mm2s_busy;
        stat_word[dma_regs_pkg::STAT_S2MM_BUSY] = status_i.s2mm_busy;
        stat_word[dma_regs_pkg::STAT_S2MM_IRQ]  = status_i.s2mm_irq;
        case (rd_sel)
            dma_regs_pkg::SEL_CTRL:      rd_mux = cfg_i.ctrl;
            dma_regs_pkg::SEL_STATUS:    rd_mux = stat_word;
            dma_regs_pkg::SEL_S2MM_ADDR: rd_mux = cfg_i.s2mm_addr;
            dma_regs_pkg::SEL_S2MM_LEN:  rd_mux = cfg_i.s2mm_len;
            dma_regs_pkg::SEL_MM2S_ADDR: rd_mux = cfg_i.mm2s_addr;
            dma_regs_pkg::SEL_MM2S_LEN:  rd_mux = cfg_i.mm2s_len;
            default:                     rd_mux = '0;  // Unmapped reads zero
        endcase
    end

    // ------------------------------------------------------------------------
    // Channel FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= dma_regs_pkg::RD_ADDR;
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rresp_o   <= dma_regs_pkg::RESP_OKAY;
        end else if (state_q == dma_regs_pkg::RD_ADDR) begin
            arready_o <= !ar_hs;                 // Drops for the data phase
            if (ar_hs) begin
                rvalid_o <= 1'b1;
                rresp_o  <= (rd_sel == dma_regs_pkg::SEL_NONE) ? dma_regs_pkg::RESP_SLVERR
                                                               : dma_regs_pkg::RESP_OKAY;
                state_q  <= dma_regs_pkg::RD_RESP;
            end
        end else if (r_hs) begin
            rvalid_o  <= 1'b0;
            arready_o <= 1'b1;
            state_q   <= dma_regs_pkg::RD_ADDR;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_hs) rdata_q <= rd_mux;
    end

    assign rdata_o = rvalid_o ? rdata_q : '0;    // Zero outside the data phase

    // Data and response frozen while the master stalls
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

endmodule

// File: hdl/dma_regs_top.sv
// ---------------------------------------------------------------------------
// AXI4-Lite register file for a two channel DMA, top level
// Write controller, register bank and read controller
// DMA control outputs, status packing, combined interrupt
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module dma_regs_top #(
    parameter int unsigned AXI_ADDR_W = 32
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    // AXI4-Lite slave
    input  logic [AXI_ADDR_W-1:0]           s_axi_awaddr_i,
    input  logic                            s_axi_awvalid_i,
    output logic                            s_axi_awready_o,
    input  logic [dma_regs_pkg::DATA_W-1:0] s_axi_wdata_i,
    input  logic [dma_regs_pkg::STRB_W-1:0] s_axi_wstrb_i,
    input  logic                            s_axi_wvalid_i,
    output logic                            s_axi_wready_o,
    output dma_regs_pkg::axi_resp_e         s_axi_bresp_o,
    output logic                            s_axi_bvalid_o,
    input  logic                            s_axi_bready_i,
    input  logic [AXI_ADDR_W-1:0]           s_axi_araddr_i,
    input  logic                            s_axi_arvalid_i,
    output logic                            s_axi_arready_o,
    output logic [dma_regs_pkg::DATA_W-1:0] s_axi_rdata_o,
    output dma_regs_pkg::axi_resp_e         s_axi_rresp_o,
    output logic                            s_axi_rvalid_o,
    input  logic                            s_axi_rready_i,
    // S2MM channel setup
    output logic                            s2mm_start_o,
    output logic [dma_regs_pkg::DATA_W-1:0] s2mm_dest_addr_o,
    output logic [dma_regs_pkg::DATA_W-1:0] s2mm_length_o,
    output logic                            s2mm_reset_o,
    // MM2S channel setup
    output logic                            mm2s_start_o,
    output logic [dma_regs_pkg::DATA_W-1:0] mm2s_src_addr_o,
    output logic [dma_regs_pkg::DATA_W-1:0] mm2s_length_o,
    output logic                            mm2s_reset_o,
    // Channel status
    input  logic                            s2mm_busy_i,
    input  logic                            mm2s_busy_i,
    input  logic                            s2mm_irq_i,
    input  logic                            mm2s_irq_i,
    output logic                            irq_o
);

    dma_regs_pkg::reg_wr_t     wr_req;
    dma_regs_pkg::dma_cfg_t    cfg;
    dma_regs_pkg::dma_status_t status;

    assign status = '{mm2s_busy: mm2s_busy_i, s2mm_busy: s2mm_busy_i,
                      mm2s_irq:  mm2s_irq_i,  s2mm_irq:  s2mm_irq_i};

    axil_write_ctrl #(.AXI_ADDR_W(AXI_ADDR_W)) axil_write_ctrl_i (
        .clk_i, .rst_ni,
        .awaddr_i (s_axi_awaddr_i),  .awvalid_i (s_axi_awvalid_i), .awready_o (s_axi_awready_o),
        .wdata_i  (s_axi_wdata_i),   .wstrb_i   (s_axi_wstrb_i),
        .wvalid_i (s_axi_wvalid_i),  .wready_o  (s_axi_wready_o),
        .bresp_o  (s_axi_bresp_o),   .bvalid_o  (s_axi_bvalid_o),  .bready_i  (s_axi_bready_i),
        .wr_req_o (wr_req)
    );

    dma_cfg_regs dma_cfg_regs_i (.clk_i, .rst_ni, .wr_req_i (wr_req), .cfg_o (cfg));

    axil_read_ctrl #(.AXI_ADDR_W(AXI_ADDR_W)) axil_read_ctrl_i (
        .clk_i, .rst_ni,
        .araddr_i (s_axi_araddr_i),  .arvalid_i (s_axi_arvalid_i), .arready_o (s_axi_arready_o),
        .rdata_o  (s_axi_rdata_o),   .rresp_o   (s_axi_rresp_o),
        .rvalid_o (s_axi_rvalid_o),  .rready_i  (s_axi_rready_i),
        .cfg_i    (cfg),             .status_i  (status)
    );

    // ------------------------------------------------------------------------
    // DMA channel outputs
    // ------------------------------------------------------------------------
    assign mm2s_start_o     = cfg.ctrl[dma_regs_pkg::CTRL_MM2S_START];
    assign s2mm_start_o     = cfg.ctrl[dma_regs_pkg::CTRL_S2MM_START];
    assign mm2s_reset_o     = cfg.ctrl[dma_regs_pkg::CTRL_MM2S_RST];  // Soft reset
    assign s2mm_reset_o     = cfg.ctrl[dma_regs_pkg::CTRL_S2MM_RST];
    assign s2mm_dest_addr_o = cfg.s2mm_addr;
    assign s2mm_length_o    = cfg.s2mm_len;
    assign mm2s_src_addr_o  = cfg.mm2s_addr;
    assign mm2s_length_o    = cfg.mm2s_len;

    assign irq_o = status.s2mm_irq | status.mm2s_irq;  // Unmasked, either channel

endmodule

// File: sim/tb_axil_tasks.svh
// ---------------------------------------------------------------------------
// AXI4-Lite master tasks for the DMA register file testbench
// Value check, queued expectation, write and read with random B/R delay
// ---------------------------------------------------------------------------
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Compare one value, count it, report a mismatch at once
task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
    end
endtask

// Hand a pair to the compare process
task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
    -> cmp_ev;
endtask

// Called on a falling edge, returns on a falling edge
task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output logic [1:0] resp);
    int delay;
    delay   = $random(seed) & 3;               // B back-pressure 0 to 3 cycles
    awaddr  = addr;
    awvalid = 1'b1;
    while (!awready) @(negedge clk);
    @(negedge clk);                            // AW taken at the edge before
    awvalid = 1'b0;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    expect_eq("wready_o", wready, 1'b1);       // Data phase opens right after AW
    while (!wready) @(negedge clk);
    @(negedge clk);
    wvalid = 1'b0;
    while (!bvalid) @(negedge clk);
    resp = bresp;
    repeat (delay) begin                       // Stalled response must hold
        @(negedge clk);
        expect_eq("bvalid_o", bvalid, 1'b1);
        expect_eq("bresp_o hold", bresp, resp);
        expect_eq("awready_o", awready, 1'b0);  // No second AW in flight
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
endtask

task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    int delay;
    delay   = $random(seed) & 3;               // R back-pressure
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    repeat (delay) begin
        @(negedge clk);
        expect_eq("rvalid_o", rvalid, 1'b1);
        expect_eq("rdata_o hold", rdata, data);
        expect_eq("rresp_o hold", rresp, resp);
        expect_eq("arready_o", arready, 1'b0);  // No second AR in flight
    end
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
    expect_eq("rdata_o idle", rdata, 32'h0);   // Zero once rvalid drops
endtask

`endif

// File: sim/tb_dma_regs_top.sv
// ---------------------------------------------------------------------------
// Testbench for the DMA register file
// Clock, reset, reference model, compare process, test sequence, timeout
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_dma_regs_top;

    localparam int unsigned N_XFERS    = 65;                   // Bus transfers, all tests
    localparam int unsigned MAX_CYCLES = 20 * N_XFERS + 100;   // Margin for reset
    localparam logic [7:0] WORD_ADDR [5] = '{8'h00, 8'h10, 8'h14, 8'h20, 8'h24};
    localparam logic [7:0] BAD_WR [5]    = '{8'h04, 8'h08, 8'h02, 8'h30, 8'h13};
    localparam logic [7:0] BAD_RD [5]    = '{8'h08, 8'h0c, 8'h28, 8'h01, 8'hfc};
    localparam logic [31:0] CTRL_PAT [4] = '{32'h001, 32'h002, 32'h100, 32'h200};

    logic        clk;
    logic        rst_n;
    logic [31:0] awaddr, araddr, wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic        s2mm_start, s2mm_reset, mm2s_start, mm2s_reset;
    logic [31:0] s2mm_dest_addr, s2mm_length, mm2s_src_addr, mm2s_length;
    logic        s2mm_busy, mm2s_busy, s2mm_irq, mm2s_irq, irq;

    logic [4:0][31:0] model;      // ctrl, s2mm addr, s2mm len, mm2s addr, mm2s len
    int          seed = 37535;
    int          cycles, chk_cnt, err_cnt, test_cnt, fail_cnt, test_err_base;
    string       name_q[$];
    logic [31:0] got_q[$];
    logic [31:0] exp_q[$];
    event        cmp_ev;

    `include "tb_axil_tasks.svh"

    dma_regs_top #(.AXI_ADDR_W(32)) dma_regs_top_i (
        .clk_i (clk), .rst_ni (rst_n),
        .s_axi_awaddr_i (awaddr), .s_axi_awvalid_i (awvalid), .s_axi_awready_o (awready),
        .s_axi_wdata_i  (wdata),  .s_axi_wstrb_i   (wstrb),
        .s_axi_wvalid_i (wvalid), .s_axi_wready_o  (wready),
        .s_axi_bresp_o  (bresp),  .s_axi_bvalid_o  (bvalid),  .s_axi_bready_i (bready),
        .s_axi_araddr_i (araddr), .s_axi_arvalid_i (arvalid), .s_axi_arready_o (arready),
        .s_axi_rdata_o  (rdata),  .s_axi_rresp_o   (rresp),
        .s_axi_rvalid_o (rvalid), .s_axi_rready_i  (rready),
        .s2mm_start_o (s2mm_start), .s2mm_dest_addr_o (s2mm_dest_addr),
        .s2mm_length_o (s2mm_length), .s2mm_reset_o (s2mm_reset),
        .mm2s_start_o (mm2s_start), .mm2s_src_addr_o (mm2s_src_addr),
        .mm2s_length_o (mm2s_length), .mm2s_reset_o (mm2s_reset),
        .s2mm_busy_i (s2mm_busy), .mm2s_busy_i (mm2s_busy),
        .s2mm_irq_i (s2mm_irq), .mm2s_irq_i (mm2s_irq), .irq_o (irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                 // 8 ns period
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a bus handshake never completed", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Compare process, drains everything queued so far
    always @(cmp_ev) begin
        while (got_q.size() > 0) begin
            check_eq(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
        end
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    // Writable word index, -1 for status, unmapped or misaligned
    function automatic int word_index(input logic [31:0] addr);
        case (addr[7:0])
            8'h00:   return 0;
            8'h10:   return 1;
            8'h14:   return 2;
            8'h20:   return 3;
            8'h24:   return 4;
            default: return -1;
        endcase
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    // Expected read data, response through resp
    function automatic logic [31:0] ref_read(input logic [31:0] addr,
                                             input logic [4:0][31:0] regs,
                                             input logic mm2s_bsy, s2mm_bsy, s2mm_irq_in,
                                             output logic [1:0] resp);
        resp = 2'b00;
        if (addr[7:0] == 8'h04) begin
            return {29'd0, s2mm_irq_in, s2mm_bsy, mm2s_bsy};   // mm2s irq not shown
        end
        if (word_index(addr) >= 0) begin
            return regs[word_index(addr)];
        end
        resp = 2'b10;                          // SLVERR, zero data
        return 32'h0;
    endfunction

    task automatic write_model(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        logic [1:0] resp;
        int         idx;
        idx = word_index(addr);
        axil_write(addr, data, strb, resp);
        expect_eq("bresp_o", resp, (idx >= 0) ? 2'b00 : 2'b10);
        if (idx >= 0) model[idx] = merge_bytes(model[idx], data, strb);
    endtask

    task automatic read_check(input logic [31:0] addr);
        logic [31:0] data;
        logic [31:0] exp;
        logic [1:0]  resp;
        logic [1:0]  exp_resp;
        axil_read(addr, data, resp);
        exp = ref_read(addr, model, mm2s_busy, s2mm_busy, s2mm_irq, exp_resp);
        expect_eq("rdata_o", data, exp);
        expect_eq("rresp_o", resp, exp_resp);
    endtask

    task automatic check_dma_outputs();
        expect_eq("mm2s_start_o", mm2s_start, model[0][0]);
        expect_eq("s2mm_start_o", s2mm_start, model[0][1]);
        expect_eq("mm2s_reset_o", mm2s_reset, model[0][8]);
        expect_eq("s2mm_reset_o", s2mm_reset, model[0][9]);
        expect_eq("s2mm_dest_addr_o", s2mm_dest_addr, model[1]);
        expect_eq("s2mm_length_o", s2mm_length, model[2]);
        expect_eq("mm2s_src_addr_o", mm2s_src_addr, model[3]);
        expect_eq("mm2s_length_o", mm2s_length, model[4]);
    endtask

    task automatic end_test(input string name);
        @(negedge clk);                        // Compare process catches up
        test_cnt++;
        if (err_cnt != test_err_base) fail_cnt++;
        $display("Test %0d %-12s %s, %0d errors", test_cnt, name,
                 (err_cnt == test_err_base) ? "ok" : "mismatch", err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int idx;
        rst_n     = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        s2mm_busy = 1'b0;
        mm2s_busy = 1'b0;
        s2mm_irq  = 1'b0;
        mm2s_irq  = 1'b0;
        model     = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < 5; i++) begin     // Full words
            write_model(WORD_ADDR[i], $random(seed), 4'hf);
        end
        for (int i = 0; i < 5; i++) begin
            read_check(WORD_ADDR[i]);
        end
        end_test("full_word");

        for (int i = 0; i < 8; i++) begin
            idx = $unsigned($random(seed)) % 5;
            write_model(WORD_ADDR[idx], $random(seed), 4'($random(seed)));
            read_check(WORD_ADDR[idx]);
        end
        end_test("strobe");

        for (int i = 0; i < 5; i++) begin     // Model must not move
            write_model(BAD_WR[i], $random(seed), 4'hf);
        end
        for (int i = 0; i < 5; i++) begin
            read_check(WORD_ADDR[i]);
        end
        for (int i = 0; i < 5; i++) begin
            read_check(BAD_RD[i]);
        end
        end_test("slverr");

        for (int i = 0; i < 4; i++) begin     // Walking control bit, random spare bits
            write_model(32'h00, CTRL_PAT[i] | ($random(seed) & 32'hffff_fc00), 4'hf);
            check_dma_outputs();
        end
        end_test("ctrl_out");

        for (int i = 0; i < 8; i++) begin
            {s2mm_busy, mm2s_busy, s2mm_irq, mm2s_irq} = 4'($random(seed));
            read_check(32'h04);
            expect_eq("irq_o", irq, s2mm_irq | mm2s_irq);
        end
        end_test("status_irq");

        for (int i = 0; i < 6; i++) begin     // Back to back under back-pressure
            idx = $unsigned($random(seed)) % 5;
            write_model(WORD_ADDR[idx], $random(seed), 4'hf);
            read_check(WORD_ADDR[idx]);
        end
        end_test("backpress");

        $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 test_cnt, fail_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+sim
hdl/dma_regs_pkg.sv
hdl/axil_write_ctrl.sv
hdl/dma_cfg_regs.sv
hdl/axil_read_ctrl.sv
hdl/dma_regs_top.sv
sim/tb_dma_regs_top.sv

// File: Bender.yml
package:
  name: dma_regs

sources:
  - hdl/dma_regs_pkg.sv
  - hdl/axil_write_ctrl.sv
  - hdl/dma_cfg_regs.sv
  - hdl/axil_read_ctrl.sv
  - hdl/dma_regs_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_dma_regs_top.sv
